// File: common/apu_params.svh
`ifndef APU_PARAMS_SVH
`define APU_PARAMS_SVH

// AXI4-Lite widths
`define APU_ADDR_W 8
`define APU_DATA_W 32

// Register map, in 32-bit word offsets
`define APU_REG_P1 0
`define APU_REG_P2 4
`define APU_REG_STATUS 21

// Channel ticks per quarter frame
`define APU_QFRAME_TICKS 3729

`endif

// File: common/apu_bus_pkg.sv
`include "apu_params.svh"

package apu_bus_pkg;

	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} axil_resp_e;

	typedef struct packed {
		logic                       awvalid;
		logic [`APU_ADDR_W-1:0]     awaddr;
		logic                       wvalid;
		logic [`APU_DATA_W-1:0]     wdata;
		logic [`APU_DATA_W/8-1:0]   wstrb;
		logic                       bready;
		logic                       arvalid;
		logic [`APU_ADDR_W-1:0]     araddr;
		logic                       rready;
	} axil_req_t;

	typedef struct packed {
		logic                   awready;
		logic                   wready;
		logic                   bvalid;
		axil_resp_e             bresp;
		logic                   arready;
		logic                   rvalid;
		logic [`APU_DATA_W-1:0] rdata;
		axil_resp_e             rresp;
	} axil_rsp_t;

endpackage

// File: common/apu_chan_pkg.sv
package apu_chan_pkg;

	// Register 0
	typedef struct packed {
		logic [1:0] duty;
		logic       halt;
		logic       const_vol;
		logic [3:0] volume;
	} pulse_ctrl_t;

	// Register 1
	typedef struct packed {
		logic       enable;
		logic [2:0] period;
		logic       negate;
		logic [2:0] shift;
	} pulse_sweep_t;

	// Register 3
	typedef struct packed {
		logic [4:0] len_idx;
		logic [2:0] timer_hi;
	} pulse_hi_t;

	// One written byte, meaning set by the register index
	typedef union packed {
		pulse_ctrl_t  ctrl;
		pulse_sweep_t sweep;
		logic [7:0]   timer_lo;
		pulse_hi_t    hi;
	} pulse_reg_u;

	typedef struct packed {
		pulse_ctrl_t  ctrl;
		pulse_sweep_t sweep;
		logic [7:0]   timer_lo;
		pulse_hi_t    hi;
	} pulse_regs_t;

	typedef struct packed {
		logic wr_sweep;
		logic wr_hi;
	} pulse_wr_t;

	typedef struct packed {
		logic tick;
		logic qframe;
		logic hframe;
	} frame_strb_t;

endpackage

// File: src/apu_axil_regs.sv
`timescale 1ns/1ns
`include "apu_params.svh"

module apu_axil_regs (
	input  logic                      clk,
	input  logic                      rst_n,
	input  apu_bus_pkg::axil_req_t    bus_req,
	output apu_bus_pkg::axil_rsp_t    bus_rsp,
	output apu_chan_pkg::pulse_regs_t regs_p1,
	output apu_chan_pkg::pulse_regs_t regs_p2,
	output apu_chan_pkg::pulse_wr_t   wr_p1,
	output apu_chan_pkg::pulse_wr_t   wr_p2,
	output logic [1:0]                en,
	input  logic [1:0]                act
);

	localparam int WORD_W = `APU_ADDR_W - 2;

	function automatic logic in_block(input logic [WORD_W-1:0] word, input int base);
		logic [WORD_W-1:0] off;
		off = word - WORD_W'(base);
		return off[WORD_W-1:2] == '0;
	endfunction

	function automatic apu_chan_pkg::pulse_regs_t reg_write(
		input apu_chan_pkg::pulse_regs_t cur,
		input logic [1:0]                idx,
		input apu_chan_pkg::pulse_reg_u  b
	);
		apu_chan_pkg::pulse_regs_t nxt;
		nxt = cur;
		case (idx)
			2'd0: nxt.ctrl = b.ctrl;
			2'd1: nxt.sweep = b.sweep;
			2'd2: nxt.timer_lo = b.timer_lo;
			default: nxt.hi = b.hi;
		endcase
		return nxt;
	endfunction

	function automatic logic [7:0] reg_read(
		input apu_chan_pkg::pulse_regs_t cur,
		input logic [1:0]                idx
	);
		apu_chan_pkg::pulse_reg_u b;
		case (idx)
			2'd0: b.ctrl = cur.ctrl;
			2'd1: b.sweep = cur.sweep;
			2'd2: b.timer_lo = cur.timer_lo;
			default: b.hi = cur.hi;
		endcase
		return b;
	endfunction

	logic                    bvalid;
	logic                    rvalid;
	apu_bus_pkg::axil_resp_e bresp;
	apu_bus_pkg::axil_resp_e rresp;
	logic [`APU_DATA_W-1:0]  rdata;

	logic wr_take, rd_take, wr_ok;
	assign wr_take = bus_req.awvalid & bus_req.wvalid & ~bvalid;
	assign rd_take = bus_req.arvalid & ~rvalid;
	assign wr_ok = wr_take & bus_req.wstrb[0];

	logic [WORD_W-1:0] w_word, r_word;
	assign w_word = bus_req.awaddr[`APU_ADDR_W-1:2];
	assign r_word = bus_req.araddr[`APU_ADDR_W-1:2];

	logic w_p1, w_p2, w_stat, r_p1, r_p2, r_stat;
	assign w_p1 = in_block(w_word, `APU_REG_P1);
	assign w_p2 = in_block(w_word, `APU_REG_P2);
	assign w_stat = w_word == WORD_W'(`APU_REG_STATUS);
	assign r_p1 = in_block(r_word, `APU_REG_P1);
	assign r_p2 = in_block(r_word, `APU_REG_P2);
	assign r_stat = r_word == WORD_W'(`APU_REG_STATUS);

	apu_chan_pkg::pulse_reg_u wbyte;
	assign wbyte = bus_req.wdata[7:0];

	logic [1:0] en_nxt;
	assign en_nxt = (wr_ok && w_stat) ? bus_req.wdata[1:0] : en;

	// Disabled channels hold cleared registers and ignore writes
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			en <= 2'b00;
			regs_p1 <= '0;
			regs_p2 <= '0;
			wr_p1 <= '0;
			wr_p2 <= '0;
		end else begin
			en <= en_nxt;
			if (!en_nxt[0])
				regs_p1 <= '0;
			else if (wr_ok && w_p1)
				regs_p1 <= reg_write(regs_p1, w_word[1:0], wbyte);
			if (!en_nxt[1])
				regs_p2 <= '0;
			else if (wr_ok && w_p2)
				regs_p2 <= reg_write(regs_p2, w_word[1:0], wbyte);
			wr_p1.wr_sweep <= wr_ok & w_p1 & en[0] & (w_word[1:0] == 2'd1);
			wr_p1.wr_hi <= wr_ok & w_p1 & en[0] & (w_word[1:0] == 2'd3);
			wr_p2.wr_sweep <= wr_ok & w_p2 & en[1] & (w_word[1:0] == 2'd1);
			wr_p2.wr_hi <= wr_ok & w_p2 & en[1] & (w_word[1:0] == 2'd3);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bvalid <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			if (wr_take)
				bvalid <= 1'b1;
			else if (bus_req.bready)
				bvalid <= 1'b0;
			if (rd_take)
				rvalid <= 1'b1;
			else if (bus_req.rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_take)
			bresp <= (w_p1 | w_p2 | w_stat) ? apu_bus_pkg::OKAY : apu_bus_pkg::SLVERR;
		if (rd_take) begin
			rresp <= (r_p1 | r_p2 | r_stat) ? apu_bus_pkg::OKAY : apu_bus_pkg::SLVERR;
			if (r_p1)
				rdata <= {{(`APU_DATA_W-8){1'b0}}, reg_read(regs_p1, r_word[1:0])};
			else if (r_p2)
				rdata <= {{(`APU_DATA_W-8){1'b0}}, reg_read(regs_p2, r_word[1:0])};
			else if (r_stat)
				rdata <= {{(`APU_DATA_W-2){1'b0}}, act};
			else
				rdata <= '0;
		end
	end

	assign bus_rsp = '{
		awready: ~bvalid,
		wready:  ~bvalid,
		bvalid:  bvalid,
		bresp:   bresp,
		arready: ~rvalid,
		rvalid:  rvalid,
		rdata:   rdata,
		rresp:   rresp
	};

endmodule

// File: src/apu_frame_seq.sv
`timescale 1ns/1ns
`include "apu_params.svh"

module apu_frame_seq (
	input  logic                      clk,
	input  logic                      rst_n,
	output apu_chan_pkg::frame_strb_t strb
);

	localparam int QT = `APU_QFRAME_TICKS;
	localparam int QW = $clog2(QT);

	logic          tick_q;
	logic [QW-1:0] qcnt;
	logic          half;
	logic          qlast;

	assign qlast = tick_q && (qcnt == QW'(QT - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tick_q <= 1'b0;
			qcnt <= '0;
			half <= 1'b0;
		end else begin
			tick_q <= ~tick_q;
			if (qlast) begin
				qcnt <= '0;
				half <= ~half;
			end else if (tick_q) begin
				qcnt <= qcnt + 1'b1;
			end
		end
	end

	// Half frame on every other quarter frame
	assign strb = '{tick: tick_q, qframe: qlast, hframe: qlast & half};

endmodule

// File: pulse/apu_envelope.sv
`timescale 1ns/1ns

module apu_envelope (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       qframe,
	input  logic       restart,
	input  logic       loop,
	input  logic       const_vol,
	input  logic [3:0] volume,
	output logic [3:0] out
);

	logic [3:0] div;
	logic [3:0] decay;

	// Volume field doubles as the divider period
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			div <= 4'd0;
			decay <= 4'd0;
		end else if (restart) begin
			div <= volume;
			decay <= 4'd15;
		end else if (qframe) begin
			if (div == 4'd0) begin
				div <= volume;
				if (decay != 4'd0)
					decay <= decay - 4'd1;
				else if (loop)
					decay <= 4'd15;
			end else begin
				div <= div - 4'd1;
			end
		end
	end

	assign out = const_vol ? volume : decay;

endmodule

// File: pulse/apu_length_counter.sv
`timescale 1ns/1ns

module apu_length_counter (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       hframe,
	input  logic       en,
	input  logic       halt,
	input  logic       load,
	input  logic [4:0] idx,
	output logic       act
);

	// Length in half frames, indexed by the 5-bit load value
	localparam logic [7:0] LEN_TAB [32] = '{
		8'd10,  8'd254, 8'd20,  8'd2,   8'd40,  8'd4,   8'd80,  8'd6,
		8'd160, 8'd8,   8'd60,  8'd10,  8'd14,  8'd12,  8'd26,  8'd14,
		8'd12,  8'd16,  8'd24,  8'd18,  8'd48,  8'd20,  8'd96,  8'd22,
		8'd192, 8'd24,  8'd72,  8'd26,  8'd16,  8'd28,  8'd32,  8'd30
	};

	logic [7:0] cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= 8'd0;
		end else if (!en) begin
			cnt <= 8'd0;
		end else if (load) begin
			cnt <= LEN_TAB[idx];
		end else if (hframe && !halt && cnt != 8'd0) begin
			cnt <= cnt - 8'd1;
		end
	end

	assign act = cnt != 8'd0;

endmodule

// File: pulse/apu_pulse.sv
`timescale 1ns/1ns

module apu_pulse #(
	parameter logic ones_comp_neg = 1'b0
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  apu_chan_pkg::pulse_regs_t regs,
	input  apu_chan_pkg::pulse_wr_t   wr,
	input  apu_chan_pkg::frame_strb_t strb,
	input  logic                      en,
	output logic                      act,
	output logic [3:0]                out
);

	logic [3:0] env_out;

	apu_envelope i_envelope (
		.clk       (clk),
		.rst_n     (rst_n),
		.qframe    (strb.qframe),
		.restart   (wr.wr_hi),
		.loop      (regs.ctrl.halt),
		.const_vol (regs.ctrl.const_vol),
		.volume    (regs.ctrl.volume),
		.out       (env_out)
	);

	apu_length_counter i_length (
		.clk    (clk),
		.rst_n  (rst_n),
		.hframe (strb.hframe),
		.en     (en),
		.halt   (regs.ctrl.halt),
		.load   (wr.wr_hi),
		.idx    (regs.hi.len_idx),
		.act    (act)
	);

	logic [10:0] reg_period;
	assign reg_period = {regs.hi.timer_hi, regs.timer_lo};

	// Sweep target, carry out of the adder flags an upward overflow
	logic [10:0] delta;
	logic [11:0] swp_sum;
	logic        swp_mute;
	logic [10:0] period;

	assign delta = period >> regs.sweep.shift;
	assign swp_sum = {1'b0, period} + {1'b0, regs.sweep.negate ? ~delta : delta}
		+ 12'(regs.sweep.negate & ~ones_comp_neg);
	assign swp_mute = ~regs.sweep.negate & swp_sum[11];

	logic [2:0] swp_div;
	logic       swp_reload;
	logic       swp_apply;

	assign swp_apply = strb.hframe && swp_div == 3'd0 && regs.sweep.enable
		&& regs.sweep.shift != 3'd0 && !swp_mute;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			swp_div <= 3'd0;
			swp_reload <= 1'b0;
		end else if (!en) begin
			swp_div <= 3'd0;
			swp_reload <= 1'b0;
		end else begin
			if (wr.wr_sweep)
				swp_reload <= 1'b1;
			else if (strb.hframe)
				swp_reload <= 1'b0;
			if (strb.hframe) begin
				if (swp_reload || swp_div == 3'd0)
					swp_div <= regs.sweep.period;
				else
					swp_div <= swp_div - 3'd1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			period <= 11'd0;
		else if (!en)
			period <= 11'd0;
		else if (wr.wr_hi)
			period <= reg_period;
		else if (swp_apply)
			period <= swp_sum[10:0];
	end

	logic [10:0] timer;
	logic [2:0]  seq;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			timer <= 11'd0;
			seq <= 3'd0;
		end else if (!en) begin
			timer <= 11'd0;
			seq <= 3'd0;
		end else if (wr.wr_hi) begin
			timer <= reg_period;
			seq <= 3'd0;
		end else if (strb.tick) begin
			if (timer == 11'd0) begin
				timer <= period;
				seq <= seq - 3'd1;
			end else begin
				timer <= timer - 11'd1;
			end
		end
	end

	// 1/8, 2/8, 4/8 and 6/8 patterns
	logic duty_hi;
	always_comb begin
		case (regs.ctrl.duty)
			2'd0: duty_hi = seq == 3'b111;
			2'd1: duty_hi = seq[2:1] == 2'b11;
			2'd2: duty_hi = seq[2];
			default: duty_hi = seq[2:1] != 2'b11;
		endcase
	end

	logic gate;
	assign gate = en & act & (period[10:3] != 8'd0) & ~swp_mute & duty_hi;
	assign out = gate ? env_out : 4'd0;

endmodule

// File: src/apu_top.sv
`timescale 1ns/1ns

module apu_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  apu_bus_pkg::axil_req_t bus_req,
	output apu_bus_pkg::axil_rsp_t bus_rsp,
	output logic [4:0]             sample
);

	apu_chan_pkg::pulse_regs_t regs_p1, regs_p2;
	apu_chan_pkg::pulse_wr_t   wr_p1, wr_p2;
	apu_chan_pkg::frame_strb_t strb;
	logic [1:0]                en;
	logic [1:0]                act;
	logic [3:0]                out_p1, out_p2;

	apu_axil_regs i_axil_regs (
		.clk     (clk),
		.rst_n   (rst_n),
		.bus_req (bus_req),
		.bus_rsp (bus_rsp),
		.regs_p1 (regs_p1),
		.regs_p2 (regs_p2),
		.wr_p1   (wr_p1),
		.wr_p2   (wr_p2),
		.en      (en),
		.act     (act)
	);

	apu_frame_seq i_frame_seq (
		.clk   (clk),
		.rst_n (rst_n),
		.strb  (strb)
	);

	// First channel negates with ones complement
	apu_pulse #(.ones_comp_neg(1'b1)) i_pulse1 (
		.clk   (clk),
		.rst_n (rst_n),
		.regs  (regs_p1),
		.wr    (wr_p1),
		.strb  (strb),
		.en    (en[0]),
		.act   (act[0]),
		.out   (out_p1)
	);

	apu_pulse #(.ones_comp_neg(1'b0)) i_pulse2 (
		.clk   (clk),
		.rst_n (rst_n),
		.regs  (regs_p2),
		.wr    (wr_p2),
		.strb  (strb),
		.en    (en[1]),
		.act   (act[1]),
		.out   (out_p2)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			sample <= 5'd0;
		else
			sample <= {1'b0, out_p1} + {1'b0, out_p2};
	end

endmodule

// File: sim/apu_tb_tasks.svh
`ifndef APU_TB_TASKS_SVH
`define APU_TB_TASKS_SVH

function automatic logic [ADDR_W-1:0] word_addr(input int word);
	return ADDR_W'(word * 4);
endfunction

// Length in half frames for each 5-bit load index
function automatic int len_table(input logic [4:0] idx);
	int tab [32];
	tab = '{10, 254, 20, 2, 40, 4, 80, 6, 160, 8, 60, 10, 14, 12, 26, 14,
		12, 16, 24, 18, 48, 20, 96, 22, 192, 24, 72, 26, 16, 28, 32, 30};
	return tab[idx];
endfunction

// High steps out of the eight sequencer steps
function automatic int duty_high_steps(input logic [1:0] duty);
	logic [7:0] pattern;
	case (duty)
		2'd0: pattern = 8'b0100_0000;
		2'd1: pattern = 8'b0110_0000;
		2'd2: pattern = 8'b0111_1000;
		default: pattern = 8'b1001_1111;
	endcase
	return $countones(pattern);
endfunction

task automatic axil_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
		output apu_bus_pkg::axil_resp_e resp);
	int waited;
	waited = 0;
	bus_req.awvalid = 1'b1;
	bus_req.awaddr = addr;
	bus_req.wvalid = 1'b1;
	bus_req.wdata = data;
	bus_req.wstrb = '1;
	bus_req.bready = 1'b1;
	do begin
		@(negedge clk);
		waited++;
	end while (!bus_rsp.bvalid && waited < HANDSHAKE_LIMIT);
	if (bus_rsp.bvalid) begin
		resp = bus_rsp.bresp;
	end else begin
		other_errs++;
		$display("Write to address %0h got no response", addr);
		resp = apu_bus_pkg::SLVERR;
	end
	bus_req.awvalid = 1'b0;
	bus_req.wvalid = 1'b0;
endtask

task automatic axil_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
		output apu_bus_pkg::axil_resp_e resp);
	int waited;
	waited = 0;
	bus_req.arvalid = 1'b1;
	bus_req.araddr = addr;
	bus_req.rready = 1'b1;
	do begin
		@(negedge clk);
		waited++;
	end while (!bus_rsp.rvalid && waited < HANDSHAKE_LIMIT);
	if (bus_rsp.rvalid) begin
		data = bus_rsp.rdata;
		resp = bus_rsp.rresp;
	end else begin
		other_errs++;
		$display("Read of address %0h got no response", addr);
		data = '0;
		resp = apu_bus_pkg::SLVERR;
	end
	bus_req.arvalid = 1'b0;
endtask

task automatic check_rsp(input string name, input apu_bus_pkg::axil_resp_e exp,
		input apu_bus_pkg::axil_resp_e act);
	if (act !== exp) begin
		mismatch_errs++;
		$display("MISMATCH at %0t ns: %s expected %s got %s", $time, name, exp.name(),
			act.name());
	end
endtask

task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
		input logic [DATA_W-1:0] act);
	if (act !== exp) begin
		mismatch_errs++;
		$display("MISMATCH at %0t ns: %s expected %0h got %0h", $time, name, exp, act);
	end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
	if (act !== exp) begin
		mismatch_errs++;
		$display("MISMATCH at %0t ns: %s expected %b got %b", $time, name, exp, act);
	end
endtask

// Sample must equal one of four allowed levels
task automatic check_sample(input logic [4:0] act, input logic [4:0] a, input logic [4:0] b,
		input logic [4:0] c, input logic [4:0] d);
	if (act !== a && act !== b && act !== c && act !== d) begin
		mismatch_errs++;
		$display("MISMATCH at %0t ns: sample expected one of %0d/%0d/%0d/%0d got %0d",
			$time, a, b, c, d, act);
	end
endtask

task automatic check_count(input string name, input int exp, input int tol, input int act);
	if (act < exp - tol || act > exp + tol) begin
		mismatch_errs++;
		$display("MISMATCH at %0t ns: %s expected %0d +/- %0d got %0d", $time, name, exp,
			tol, act);
	end
endtask

`endif

// File: sim/apu_tb.sv
`timescale 1ns/1ns
`include "apu_params.svh"

module apu_tb;

	localparam int ADDR_W = `APU_ADDR_W;
	localparam int DATA_W = `APU_DATA_W;
	localparam int HANDSHAKE_LIMIT = 64;
	// Two quarter frames of two-cycle ticks
	localparam int HF_CYCLES = 4 * `APU_QFRAME_TICKS;
	localparam int LEN_CAP = 16;
	localparam int AMP_CYCLES = 3000;
	localparam int DUTY_PERIOD = 15;
	localparam int DUTY_CYCLES = 16 * 16 * (DUTY_PERIOD + 1);
	localparam int MUTE_CYCLES = 1000;
	localparam int WATCHDOG_CYCLES = (LEN_CAP + 1) * HF_CYCLES + AMP_CYCLES + DUTY_CYCLES
		+ 2 * MUTE_CYCLES + 20000;

	logic                   clk;
	logic                   rst_n;
	apu_bus_pkg::axil_req_t bus_req;
	apu_bus_pkg::axil_rsp_t bus_rsp;
	logic [4:0]             sample;
	int                     mismatch_errs;
	int                     other_errs;

	`include "apu_tb_tasks.svh"

	apu_top i_apu_top (
		.clk     (clk),
		.rst_n   (rst_n),
		.bus_req (bus_req),
		.bus_rsp (bus_rsp),
		.sample  (sample)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
		$display("sim failed");
		$finish;
	end

	task automatic write_byte(input int word, input logic [7:0] b);
		apu_bus_pkg::axil_resp_e resp;
		axil_write(word_addr(word), {24'($urandom), b}, resp);
		check_rsp("bresp", apu_bus_pkg::OKAY, resp);
	endtask

	task automatic set_enable(input logic [1:0] en);
		write_byte(`APU_REG_STATUS, 8'(en));
	endtask

	task automatic expect_status(input logic [1:0] act);
		apu_bus_pkg::axil_resp_e resp;
		logic [DATA_W-1:0]       data;
		axil_read(word_addr(`APU_REG_STATUS), data, resp);
		check_rsp("rresp", apu_bus_pkg::OKAY, resp);
		check_data("status", DATA_W'(act), data);
	endtask

	task automatic program_pulse(input int ch, input apu_chan_pkg::pulse_ctrl_t ctrl,
			input logic [10:0] period, input logic [4:0] len_idx);
		apu_chan_pkg::pulse_hi_t hi;
		int                      base;
		base = (ch == 0) ? `APU_REG_P1 : `APU_REG_P2;
		hi.len_idx = len_idx;
		hi.timer_hi = period[10:8];
		write_byte(base, ctrl);
		write_byte(base + 1, 8'd0);
		write_byte(base + 2, period[7:0]);
		write_byte(base + 3, hi);
	endtask

	// Constant volume with halt so the tone never expires
	function automatic apu_chan_pkg::pulse_ctrl_t tone_ctrl(input logic [3:0] vol);
		apu_chan_pkg::pulse_ctrl_t c;
		c.duty = 2'($urandom);
		c.halt = 1'b1;
		c.const_vol = 1'b1;
		c.volume = vol;
		return c;
	endfunction

	task automatic reset_state();
		check_flag("awready", 1'b1, bus_rsp.awready);
		check_flag("wready", 1'b1, bus_rsp.wready);
		check_flag("arready", 1'b1, bus_rsp.arready);
		check_flag("bvalid", 1'b0, bus_rsp.bvalid);
		check_flag("rvalid", 1'b0, bus_rsp.rvalid);
		check_sample(sample, 5'd0, 5'd0, 5'd0, 5'd0);
		expect_status(2'b00);
	endtask

	task automatic readback_all(input logic [7:0] model [8]);
		apu_bus_pkg::axil_resp_e resp;
		logic [DATA_W-1:0]       data;
		for (int i = 0; i < 8; i++) begin
			axil_read(word_addr(i), data, resp);
			check_rsp("rresp", apu_bus_pkg::OKAY, resp);
			check_data("rdata", DATA_W'(model[3'(i)]), data);
		end
	endtask

	task automatic register_readback();
		apu_bus_pkg::axil_resp_e resp;
		logic [DATA_W-1:0]       data;
		logic [7:0]              model [8];
		logic [2:0]              w;
		logic [7:0]              b;
		int                      word;
		set_enable(2'b11);
		model = '{default: 8'd0};
		repeat (40) begin
			w = 3'($urandom);
			b = 8'($urandom);
			write_byte(int'(w), b);
			model[w] = b;
		end
		readback_all(model);
		repeat (6) begin
			word = int'($urandom_range(8, 63));
			if (word == `APU_REG_STATUS)
				word = word + 1;
			axil_write(word_addr(word), $urandom, resp);
			check_rsp("bresp", apu_bus_pkg::SLVERR, resp);
			axil_read(word_addr(word), data, resp);
			check_rsp("rresp", apu_bus_pkg::SLVERR, resp);
			check_data("rdata", '0, data);
		end
		readback_all(model);
	endtask

	task automatic length_expiry();
		apu_chan_pkg::pulse_ctrl_t c1;
		apu_chan_pkg::pulse_ctrl_t c2;
		logic [4:0]                idx1;
		idx1 = 5'($urandom);
		while (len_table(idx1) > LEN_CAP)
			idx1 = 5'($urandom);
		c1 = 8'($urandom);
		c1.halt = 1'b0;
		c2 = 8'($urandom);
		c2.halt = 1'b1;
		// Same length on both, only halt keeps the second one running
		program_pulse(0, c1, 11'($urandom), idx1);
		program_pulse(1, c2, 11'($urandom), idx1);
		expect_status(2'b11);
		repeat ((len_table(idx1) + 1) * HF_CYCLES) @(negedge clk);
		expect_status(2'b10);
	endtask

	task automatic amplitude_set();
		logic [3:0] v1;
		logic [3:0] v2;
		int         nonzero;
		set_enable(2'b00);
		set_enable(2'b11);
		v1 = 4'($urandom_range(1, 15));
		v2 = 4'($urandom_range(1, 15));
		program_pulse(0, tone_ctrl(v1), 11'($urandom_range(8, 60)), 5'($urandom));
		program_pulse(1, tone_ctrl(v2), 11'($urandom_range(8, 60)), 5'($urandom));
		repeat (4) @(negedge clk);
		nonzero = 0;
		repeat (AMP_CYCLES) begin
			@(negedge clk);
			check_sample(sample, 5'd0, {1'b0, v1}, {1'b0, v2}, {1'b0, v1} + {1'b0, v2});
			if (sample != 5'd0)
				nonzero++;
		end
		if (nonzero == 0) begin
			other_errs++;
			$display("Sample stayed at zero while both channels were sounding");
		end
	endtask

	task automatic duty_ratio();
		apu_chan_pkg::pulse_ctrl_t c;
		int                        nonzero;
		set_enable(2'b00);
		set_enable(2'b01);
		c = tone_ctrl(4'($urandom_range(1, 15)));
		program_pulse(0, c, 11'(DUTY_PERIOD), 5'($urandom));
		repeat (4) @(negedge clk);
		nonzero = 0;
		repeat (DUTY_CYCLES) begin
			@(negedge clk);
			if (sample != 5'd0)
				nonzero++;
		end
		// One sequencer step is two cycles per timer count
		check_count("nonzero samples", DUTY_CYCLES * duty_high_steps(c.duty) / 8,
			2 * (DUTY_PERIOD + 1), nonzero);
	endtask

	task automatic muting();
		apu_bus_pkg::axil_resp_e resp;
		logic [DATA_W-1:0]       data;
		logic [3:0]              v1;
		logic [3:0]              v2;
		set_enable(2'b00);
		set_enable(2'b11);
		program_pulse(0, tone_ctrl(4'($urandom_range(1, 15))), 11'($urandom_range(0, 7)),
			5'($urandom));
		program_pulse(1, tone_ctrl(4'($urandom_range(1, 15))), 11'($urandom_range(0, 7)),
			5'($urandom));
		repeat (4) @(negedge clk);
		repeat (MUTE_CYCLES) begin
			@(negedge clk);
			check_sample(sample, 5'd0, 5'd0, 5'd0, 5'd0);
		end
		v1 = 4'($urandom_range(1, 15));
		v2 = 4'($urandom_range(1, 15));
		program_pulse(0, tone_ctrl(v1), 11'($urandom_range(8, 60)), 5'($urandom));
		program_pulse(1, tone_ctrl(v2), 11'($urandom_range(8, 60)), 5'($urandom));
		set_enable(2'b10);
		repeat (4) @(negedge clk);
		repeat (MUTE_CYCLES) begin
			@(negedge clk);
			check_sample(sample, 5'd0, {1'b0, v2}, 5'd0, {1'b0, v2});
		end
		expect_status(2'b10);
		// Control byte held constant volume, so only a cleared register reads zero
		axil_read(word_addr(`APU_REG_P1), data, resp);
		check_rsp("rresp", apu_bus_pkg::OKAY, resp);
		check_data("rdata", '0, data);
	endtask

	initial begin
		void'($urandom(56526));
		mismatch_errs = 0;
		other_errs = 0;
		rst_n = 1'b0;
		bus_req = '0;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		reset_state();
		register_readback();
		length_expiry();
		amplitude_set();
		duty_ratio();
		muting();
		$display("Errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
		if (mismatch_errs == 0 && other_errs == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// File: flist.f
+incdir+common
+incdir+sim
common/apu_bus_pkg.sv
common/apu_chan_pkg.sv
src/apu_axil_regs.sv
src/apu_frame_seq.sv
pulse/apu_envelope.sv
pulse/apu_length_counter.sv
pulse/apu_pulse.sv
src/apu_top.sv
sim/apu_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -f flist.f --top-module apu_tb -o apu_sim
	out="$$(./obj_dir/apu_sim)"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
